// ==== source/femtoPkg.sv ====
/*
 * Shared definitions for the FemtoRV32 core
 * Widths, reset address, the major opcode classes of RV32I
 * and the four states of the fetch/execute machine
 */

`default_nettype none

package femtoPkg;

   // Internal address width, enough for a 16 MB space
   localparam int ADDR_WIDTH = 24;

   // Data path width
   localparam int WORD_WIDTH = 32;

   // First fetch address after reset
   localparam logic [31:0] RESET_ADDR = 32'h0000_0000;

   typedef logic [WORD_WIDTH-1:0] wordT;
   typedef logic [ADDR_WIDTH-1:0] addrT;
   typedef logic [4:0]            regIdT;

   // Major opcode, instruction bits 6 to 2
   typedef enum logic [4:0] {
      opLoad   = 5'b00000,
      opAluImm = 5'b00100,
      opAuipc  = 5'b00101,
      opStore  = 5'b01000,
      opAluReg = 5'b01100,
      opLui    = 5'b01101,
      opBranch = 5'b11000,
      opJalr   = 5'b11001,
      opJal    = 5'b11011,
      opSystem = 5'b11100
   } opcodeT;

   // Fetch/execute states
   typedef enum logic [1:0] {
      stFetchInstr,
      stWaitInstr,
      stExecute,
      stWaitAluOrMem
   } stateT;

endpackage

`default_nettype wire

// ==== source/instrDecoder.sv ====
/*
 * Instruction decoder
 * Splits the latched instruction word into its opcode class,
 * destination register, funct3 and the five immediate formats
 */

`timescale 1ns/1ns
`default_nettype none

module instrDecoder import femtoPkg::*; (
   input  logic        clk,
   input  logic        valid,
   input  logic [31:2] instr,
   output opcodeT      opcode,
   output regIdT       rdId,
   output logic [2:0]  funct3,
   output logic        isSub,
   output logic        isArith,
   output wordT        immU,
   output wordT        immI,
   output wordT        immS,
   output wordT        immB,
   output wordT        immJ
);

   // Bits 1 and 0 are always 11 in RV32I, so they are not latched
   assign opcode = opcodeT'(instr[6:2]);
   assign rdId   = instr[11:7];
   assign funct3 = instr[14:12];

   // SUB needs bit 5 too, ADDI reuses bit 30 as an immediate bit
   assign isSub   = instr[30] & instr[5];
   // Arithmetic right shift
   assign isArith = instr[30];

   // Upper immediate, low 12 bits cleared
   assign immU = {instr[31], instr[30:12], 12'b0};

   // Sign extended 12-bit immediates
   assign immI = {{21{instr[31]}}, instr[30:20]};
   assign immS = {{21{instr[31]}}, instr[30:25], instr[11:7]};

   // Branch and jump offsets, always even
   assign immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

   // The cycle after a fetch completes is the execute cycle,
   // the opcode must then be one the core knows
   assert property (@(posedge clk) valid |=> opcode inside {
      opLoad, opAluImm, opAuipc, opStore, opAluReg,
      opLui, opBranch, opJalr, opJal, opSystem
   });

endmodule

`default_nettype wire

// ==== source/registerFile.sv ====
/*
 * Register file
 * 32 words, both source operands read together when the
 * instruction fetch completes; register zero is hardwired
 */

`timescale 1ns/1ns
`default_nettype none

module registerFile import femtoPkg::*; (
   input  logic  clk,
   input  logic  readEnable,
   input  regIdT rs1Id,
   input  regIdT rs2Id,
   input  logic  writeBack,
   input  regIdT rdId,
   input  wordT  writeData,
   output wordT  rs1,
   output wordT  rs2
);

   wordT regs [32];

   // Registered dual read, x0 forced to zero
   always_ff @(posedge clk) begin
      if (readEnable) begin
         rs1 <= (rs1Id == '0) ? '0 : regs[rs1Id];
         rs2 <= (rs2Id == '0) ? '0 : regs[rs2Id];
      end
   end

   // Write port, writes to x0 dropped
   always_ff @(posedge clk) begin
      if (writeBack && rdId != '0) begin
         regs[rdId] <= writeData;
      end
   end

endmodule

`default_nettype wire

// ==== source/aluUnit.sv ====
/*
 * ALU
 * Add, subtract/compare and logic operations in one cycle,
 * shifts done serially one bit per cycle, plus the branch predicate
 */

`timescale 1ns/1ns
`default_nettype none

module aluUnit import femtoPkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  wordT       rs1,
   input  wordT       rs2,
   input  wordT       immI,
   input  opcodeT     opcode,
   input  logic [2:0] funct3,
   input  logic       isSub,
   input  logic       isArith,
   input  logic       aluStart,
   output wordT       aluOut,
   output wordT       aluPlus,
   output logic       branchTaken,
   output logic       aluBusy
);

   wordT        aluIn2;
   logic [32:0] aluMinus;
   logic        lt;
   logic        ltu;
   logic        eq;
   logic        isShift;
   wordT        shiftReg;
   logic [4:0]  shiftAmt;

   // rs2 for reg-reg ops and branches and the I immediate otherwise
   assign aluIn2 = (opcode == opAluReg || opcode == opBranch) ? rs2 : immI;

   // Shared with JALR target
   assign aluPlus = rs1 + aluIn2;

   // One 33-bit subtract gives the difference and all compares
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, rs1} + 33'd1;
   assign ltu      = aluMinus[32];
   // When the signs differ rs1 is less exactly when it is negative
   assign lt       = (rs1[31] ^ aluIn2[31]) ? rs1[31] : aluMinus[32];
   assign eq       = (aluMinus[31:0] == '0);

   // SLL is 001 and SRL/SRA are 101
   assign isShift = (funct3[1:0] == 2'b01);
   assign aluBusy = |shiftAmt;

   always_comb begin
      case (funct3)
         3'd0:    aluOut = isSub ? aluMinus[31:0] : aluPlus;
         3'd2:    aluOut = {31'b0, lt};
         3'd3:    aluOut = {31'b0, ltu};
         3'd4:    aluOut = rs1 ^ aluIn2;
         3'd6:    aluOut = rs1 | aluIn2;
         3'd7:    aluOut = rs1 & aluIn2;
         default: aluOut = shiftReg;
      endcase
   end

   // Serial shift amount counts down to zero
   always_ff @(posedge clk) begin
      if (!reset) begin
         shiftAmt <= '0;
      end else if (aluStart && isShift) begin
         shiftAmt <= aluIn2[4:0];
      end else if (aluBusy) begin
         shiftAmt <= shiftAmt - 5'd1;
      end
   end

   // Shift value register
   always_ff @(posedge clk) begin
      if (aluStart && isShift) begin
         shiftReg <= rs1;
      end else if (aluBusy) begin
         // Left for SLL and right for SRL or SRA with sign fill only for SRA
         shiftReg <= funct3[2] ? {isArith & shiftReg[31], shiftReg[31:1]}
                               : {shiftReg[30:0], 1'b0};
      end
   end

   always_comb begin
      case (funct3)
         3'd0:    branchTaken = eq;
         3'd1:    branchTaken = !eq;
         3'd4:    branchTaken = lt;
         3'd5:    branchTaken = !lt;
         3'd6:    branchTaken = ltu;
         3'd7:    branchTaken = !ltu;
         default: branchTaken = 1'b0;
      endcase
   end

   // The controller never starts a new operation while shifting
   assert property (@(posedge clk) disable iff (!reset) aluBusy |-> !aluStart);

endmodule

`default_nettype wire

// ==== source/loadStoreAlign.sv ====
/*
 * Load/store alignment
 * Forms the data address, picks and extends the addressed byte
 * or halfword on loads, and places store data on the right lanes
 */

`timescale 1ns/1ns
`default_nettype none

module loadStoreAlign import femtoPkg::*; (
   input  wordT       rs1,
   input  wordT       rs2,
   input  wordT       immI,
   input  wordT       immS,
   input  logic       isStore,
   input  logic [2:0] funct3,
   input  wordT       memRdata,
   output addrT       lsAddr,
   output wordT       loadData,
   output wordT       storeData,
   output logic [3:0] storeMask
);

   logic        byteAccess;
   logic        halfAccess;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;
   wordT        offset;

   // Stores use the S immediate, loads the I immediate
   assign offset = isStore ? immS : immI;
   assign lsAddr = rs1[ADDR_WIDTH-1:0] + offset[ADDR_WIDTH-1:0];

   // funct3[1:0]: 00 byte, 01 halfword, 10 word
   assign byteAccess = (funct3[1:0] == 2'b00);
   assign halfAccess = (funct3[1:0] == 2'b01);

   // Lane select from the low address bits
   assign loadHalf = lsAddr[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = lsAddr[0] ? loadHalf[15:8] : loadHalf[7:0];

   // funct3[2] set means LBU/LHU
   assign loadSign = !funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                                  memRdata;

   // Copy the low byte or halfword so each lane the mask selects sees it
   assign storeData[7:0]   = rs2[7:0];
   assign storeData[15:8]  = lsAddr[0] ? rs2[7:0] : rs2[15:8];
   assign storeData[23:16] = lsAddr[1] ? rs2[7:0] : rs2[23:16];
   assign storeData[31:24] = lsAddr[0] ? rs2[7:0] :
                             lsAddr[1] ? rs2[15:8] : rs2[31:24];

   always_comb begin
      if (byteAccess) begin
         storeMask = 4'b0001 << lsAddr[1:0];
      end else if (halfAccess) begin
         storeMask = lsAddr[1] ? 4'b1100 : 4'b0011;
      end else begin
         storeMask = 4'b1111;
      end
   end

endmodule

`default_nettype wire

// ==== source/fetchExecControl.sv ====
/*
 * Fetch/execute control
 * Four-state machine, program counter, instruction latch,
 * cycle counter, write-back select and memory strobes
 */

`timescale 1ns/1ns
`default_nettype none

module fetchExecControl import femtoPkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  wordT        memRdata,
   input  logic        memRbusy,
   input  logic        memWbusy,
   input  opcodeT      opcode,
   input  wordT        immU,
   input  wordT        immB,
   input  wordT        immJ,
   input  wordT        aluOut,
   input  wordT        aluPlus,
   input  wordT        loadData,
   input  logic        branchTaken,
   input  logic        aluBusy,
   input  addrT        lsAddr,
   input  logic [3:0]  storeMask,
   output logic [31:2] instr,
   output logic        readEnable,
   output logic        writeBack,
   output logic        aluStart,
   output addrT        memAddr,
   output logic        memRstrb,
   output logic [3:0]  memWmask,
   output wordT        writeData
);

   stateT state;
   addrT  pc;
   addrT  pcPlus4;
   addrT  pcPlusImm;
   wordT  pcImm;
   wordT  cycles;
   logic  isAlu;
   logic  isShift;
   logic  needToWait;
   logic  jumpToImm;

   assign isAlu   = (opcode == opAluImm) || (opcode == opAluReg);
   // funct3 is 001 or 101
   assign isShift = isAlu && (instr[13:12] == 2'b01);

   // Loads, stores and shifts finish in the wait state
   assign needToWait = (opcode == opLoad) || (opcode == opStore) || isShift;
   assign jumpToImm  = (opcode == opJal) || ((opcode == opBranch) && branchTaken);

   // One adder for branch, JAL and AUIPC targets
   assign pcImm     = (opcode == opJal)   ? immJ :
                      (opcode == opAuipc) ? immU : immB;
   assign pcPlusImm = pc + pcImm[ADDR_WIDTH-1:0];
   assign pcPlus4   = pc + addrT'(4);

   // Fetch completes when the read data is no longer busy
   assign readEnable = (state == stWaitInstr) && !memRbusy;
   assign aluStart   = (state == stExecute) && isAlu;
   assign writeBack  = !((opcode == opBranch) || (opcode == opStore)) &&
                       ((state == stExecute) || (state == stWaitAluOrMem));

   // PC drives the bus while fetching, the data address otherwise
   assign memAddr  = (state == stFetchInstr || state == stWaitInstr) ? pc : lsAddr;
   assign memRstrb = (state == stFetchInstr) ||
                     ((state == stExecute) && (opcode == opLoad));
   assign memWmask = {4{(state == stExecute) && (opcode == opStore)}} & storeMask;

   always_comb begin
      case (opcode)
         opSystem:         writeData = cycles;
         opLui:            writeData = immU;
         opAluImm,
         opAluReg:         writeData = aluOut;
         opAuipc:          writeData = {{(WORD_WIDTH-ADDR_WIDTH){1'b0}}, pcPlusImm};
         opJal,
         opJalr:           writeData = {{(WORD_WIDTH-ADDR_WIDTH){1'b0}}, pcPlus4};
         opLoad:           writeData = loadData;
         default:          writeData = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         // Start by letting any pending write drain
         state <= stWaitAluOrMem;
         pc    <= RESET_ADDR[ADDR_WIDTH-1:0];
      end else begin
         case (state)
            stFetchInstr: state <= stWaitInstr;
            stWaitInstr: begin
               if (!memRbusy) begin
                  state <= stExecute;
               end
            end
            stExecute: begin
               // JALR target has bit 0 cleared
               pc <= (opcode == opJalr) ? {aluPlus[ADDR_WIDTH-1:1], 1'b0} :
                     jumpToImm          ? pcPlusImm :
                                          pcPlus4;
               state <= needToWait ? stWaitAluOrMem : stFetchInstr;
            end
            default: begin
               if (!aluBusy && !memRbusy && !memWbusy) begin
                  state <= stFetchInstr;
               end
            end
         endcase
      end
   end

   // Instruction latch, low two bits are always 11
   always_ff @(posedge clk) begin
      if (readEnable) begin
         instr <= memRdata[31:2];
      end
   end

   // Free-running cycle counter for the SYSTEM read
   always_ff @(posedge clk) begin
      if (!reset) begin
         cycles <= '0;
      end else begin
         cycles <= cycles + 32'd1;
      end
   end

   // Fetch reads and data writes never overlap
   assert property (@(posedge clk) disable iff (!reset) !(memRstrb && |memWmask));

   // Reset always lands in the wait state
   assert property (@(posedge clk) !reset |=> state == stWaitAluOrMem);

endmodule

`default_nettype wire

// ==== source/femtoRv32.sv ====
/*
 * FemtoRV32 core top level
 * RV32I core with a cycle counter read, wired to a single
 * plain memory port shared by instruction and data accesses
 */

`timescale 1ns/1ns
`default_nettype none

module femtoRv32 import femtoPkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  wordT       memRdata,
   input  logic       memRbusy,
   input  logic       memWbusy,
   output wordT       memAddr,
   output wordT       memWdata,
   output logic [3:0] memWmask,
   output logic       memRstrb
);

   logic [31:2] instr;
   opcodeT      opcode;
   regIdT       rdId;
   logic [2:0]  funct3;
   logic        isSub;
   logic        isArith;
   wordT        immU;
   wordT        immI;
   wordT        immS;
   wordT        immB;
   wordT        immJ;
   wordT        rs1;
   wordT        rs2;
   wordT        writeData;
   logic        readEnable;
   logic        writeBack;
   logic        aluStart;
   wordT        aluOut;
   wordT        aluPlus;
   logic        branchTaken;
   logic        aluBusy;
   addrT        lsAddr;
   wordT        loadData;
   logic [3:0]  storeMask;
   addrT        coreAddr;

   // Internal address zero-extended onto the bus
   assign memAddr = {{(WORD_WIDTH-ADDR_WIDTH){1'b0}}, coreAddr};

   fetchExecControl i_fetchExecControl (
      .clk         (clk),
      .reset       (reset),
      .memRdata    (memRdata),
      .memRbusy    (memRbusy),
      .memWbusy    (memWbusy),
      .opcode      (opcode),
      .immU        (immU),
      .immB        (immB),
      .immJ        (immJ),
      .aluOut      (aluOut),
      .aluPlus     (aluPlus),
      .loadData    (loadData),
      .branchTaken (branchTaken),
      .aluBusy     (aluBusy),
      .lsAddr      (lsAddr),
      .storeMask   (storeMask),
      .instr       (instr),
      .readEnable  (readEnable),
      .writeBack   (writeBack),
      .aluStart    (aluStart),
      .memAddr     (coreAddr),
      .memRstrb    (memRstrb),
      .memWmask    (memWmask),
      .writeData   (writeData)
   );

   instrDecoder i_instrDecoder (
      .clk     (clk),
      .valid   (readEnable),
      .instr   (instr),
      .opcode  (opcode),
      .rdId    (rdId),
      .funct3  (funct3),
      .isSub   (isSub),
      .isArith (isArith),
      .immU    (immU),
      .immI    (immI),
      .immS    (immS),
      .immB    (immB),
      .immJ    (immJ)
   );

   // Source ids come straight from the word being fetched
   registerFile i_registerFile (
      .clk        (clk),
      .readEnable (readEnable),
      .rs1Id      (memRdata[19:15]),
      .rs2Id      (memRdata[24:20]),
      .writeBack  (writeBack),
      .rdId       (rdId),
      .writeData  (writeData),
      .rs1        (rs1),
      .rs2        (rs2)
   );

   aluUnit i_aluUnit (
      .clk         (clk),
      .reset       (reset),
      .rs1         (rs1),
      .rs2         (rs2),
      .immI        (immI),
      .opcode      (opcode),
      .funct3      (funct3),
      .isSub       (isSub),
      .isArith     (isArith),
      .aluStart    (aluStart),
      .aluOut      (aluOut),
      .aluPlus     (aluPlus),
      .branchTaken (branchTaken),
      .aluBusy     (aluBusy)
   );

   loadStoreAlign i_loadStoreAlign (
      .rs1       (rs1),
      .rs2       (rs2),
      .immI      (immI),
      .immS      (immS),
      .isStore   (opcode == opStore),
      .funct3    (funct3),
      .memRdata  (memRdata),
      .lsAddr    (lsAddr),
      .loadData  (loadData),
      .storeData (memWdata),
      .storeMask (storeMask)
   );

endmodule

`default_nettype wire

// ==== include/rv32RefModel.svh ====
/*
 * RV32I program generator and instruction-level reference model
 * Builds a random program in the testbench memory, then steps it
 * one instruction per fetch and queues the writes it expects
 */

`ifndef RV32_REF_MODEL_SVH
`define RV32_REF_MODEL_SVH

function automatic int rnd(input int n);
   rnd = ($random(seed) & 32'h7fff_ffff) % n;
endfunction

task automatic emit(input logic [31:0] w);
   mem[wp] = w;
   wp++;
endtask

function automatic logic [31:0] encR(input logic [6:0] f7, input int rs2, input int rs1,
                                     input int f3, input int rd, input logic [6:0] op);
   encR = {f7, 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), op};
endfunction

function automatic logic [31:0] encI(input logic [11:0] imm, input int rs1, input int f3,
                                     input int rd, input logic [6:0] op);
   encI = {imm, 5'(rs1), 3'(f3), 5'(rd), op};
endfunction

function automatic logic [31:0] encS(input logic [11:0] imm, input int rs2, input int rs1,
                                     input int f3);
   encS = {imm[11:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] encB(input logic [12:0] imm, input int rs2, input int rs1,
                                     input int f3);
   encB = {imm[12], imm[10:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:1], imm[11], 7'h63};
endfunction

function automatic logic [31:0] encJ(input logic [20:0] imm, input int rd);
   encJ = {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'h6f};
endfunction

// Offset inside the data region, aligned to the access width
function automatic int alignedOffset(input int f3);
   if (f3 % 4 == 0) begin
      alignedOffset = rnd(64) * 4 + rnd(4);
   end else if (f3 % 4 == 1) begin
      alignedOffset = rnd(64) * 4 + 2 * rnd(2);
   end else begin
      alignedOffset = rnd(64) * 4;
   end
endfunction

task automatic buildProgram();
   logic [31:0] v;
   logic [31:0] imm;
   int          kind;
   int          rd;
   int          r1;
   int          r2;
   int          f3;
   int          k;
   int          cyc;
   // Background pattern, every word differs
   for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a] = (32'(a) * 32'h9E37_79B1) ^ (32'(a) << 7);
   end
   wp  = 0;
   cyc = 0;
   // LUI plus ADDI per register, x1 holds the data base
   for (int r = 1; r < 32; r++) begin
      v = (r == 1) ? DATA_BASE : $random(seed);
      emit({v[31:12] + 20'(v[11]), 5'(r), 7'h37});
      emit(encI(v[11:0], r, 0, r, 7'h13));
   end
   for (int i = 0; i < NUM_RANDOM; i++) begin
      kind = rnd(10);
      rd   = 2 + rnd(29);
      r1   = rnd(31);
      r2   = rnd(31);
      f3   = rnd(8);
      // Jump distance in words, never past the end of the random part
      k    = 1 + rnd((NUM_RANDOM - i) < 4 ? (NUM_RANDOM - i) : 4);
      imm  = $random(seed);
      case (kind)
         0: emit(encR(((f3 == 0 || f3 == 5) && imm[12]) ? 7'h20 : 7'h00,
                      r2, r1, f3, rd, 7'h33));
         1: emit(encI((f3 == 1) ? {7'h0, imm[4:0]} :
                      (f3 == 5) ? {1'b0, imm[12], 5'h0, imm[4:0]} : imm[11:0],
                      r1, f3, rd, 7'h13));
         2: emit({imm[31:12], 5'(rd), 7'h37});
         3: emit({imm[31:12], 5'(rd), 7'h17});
         4: begin
            f3 = rnd(6);
            f3 = (f3 == 3) ? 2 : f3;
            emit(encI(12'(alignedOffset(f3)), 1, f3, rd, 7'h03));
         end
         5: begin
            f3 = rnd(3);
            emit(encS(12'(alignedOffset(f3)), r2, 1, f3));
         end
         6: begin
            f3 = rnd(6);
            f3 = (f3 >= 2) ? f3 + 2 : f3;
            emit(encB(13'(k * 4), r2, r1, f3));
         end
         7: emit(encJ(21'(k * 4), rd));
         // Absolute target from x0, bit 0 sometimes set
         8: emit(encI(12'((wp + k) * 4 + int'(imm[0])), 0, 0, rd, 7'h67));
         default: begin
            emit({12'hC00, 5'd0, 3'd2, 5'd31, 7'h73});
            emit(encS(12'(CYCLE_OFF + 4 * cyc), 31, 1, 2));
            cyc++;
         end
      endcase
   end
   for (int r = 1; r < 32; r++) begin
      emit(encS(12'(DUMP_OFF + 4 * r), r, 1, 2));
   end
   haltPc = 32'(wp * 4);
   emit(32'h0000_006f);
endtask

task automatic stepModel();
   logic [31:0] ins;
   logic [31:0] r1;
   logic [31:0] r2;
   logic [31:0] immI;
   logic [31:0] immS;
   logic [31:0] immB;
   logic [31:0] res;
   logic [31:0] addr;
   logic [31:0] w;
   logic [31:0] b;
   logic [31:0] nextPc;
   logic [4:0]  rd;
   logic [2:0]  f3;
   logic [3:0]  m;
   logic        wr;
   logic        taken;
   int          sh;
   ins    = refMem[pcModel[13:2]];
   rd     = ins[11:7];
   f3     = ins[14:12];
   r1     = regs[ins[19:15]];
   r2     = regs[ins[24:20]];
   immI   = {{20{ins[31]}}, ins[31:20]};
   immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
   immB   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
   nextPc = pcModel + 32'd4;
   res    = pcModel + 32'd4;
   wr     = 1'b1;
   taken  = 1'b0;
   case (ins[6:0])
      7'h37: res = {ins[31:12], 12'h0};
      // Address space of the core is 24 bits
      7'h17: res = (pcModel + {ins[31:12], 12'h0}) & 32'h00FF_FFFF;
      7'h6f: nextPc = pcModel + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      7'h67: nextPc = (r1 + immI) & ~32'h1;
      7'h63: begin
         wr = 1'b0;
         case (f3)
            3'd0:    taken = (r1 == r2);
            3'd1:    taken = (r1 != r2);
            3'd4:    taken = ($signed(r1) < $signed(r2));
            3'd5:    taken = ($signed(r1) >= $signed(r2));
            3'd6:    taken = (r1 < r2);
            default: taken = (r1 >= r2);
         endcase
         if (taken) begin
            nextPc = pcModel + immB;
         end
      end
      7'h03: begin
         addr = r1 + immI;
         w    = refMem[addr[13:2]] >> (8 * addr[1:0]);
         case (f3)
            3'd0:    res = {{24{w[7]}}, w[7:0]};
            3'd1:    res = {{16{w[15]}}, w[15:0]};
            3'd4:    res = {24'h0, w[7:0]};
            3'd5:    res = {16'h0, w[15:0]};
            default: res = w;
         endcase
         loadPending = 1'b1;
         loadAddr    = addr;
      end
      7'h23: begin
         wr   = 1'b0;
         addr = r1 + immS;
         m    = (f3 == 0) ? 4'b0001 << addr[1:0] :
                (f3 == 1) ? 4'b0011 << addr[1:0] : 4'b1111;
         w    = r2 << (8 * addr[1:0]);
         for (int l = 0; l < 4; l++) begin
            if (m[l]) begin
               refMem[addr[13:2]][8*l +: 8] = w[8*l +: 8];
            end
         end
         wAddrQ.push_back(addr);
         wMaskQ.push_back(m);
         wDataQ.push_back(w);
         wKnownQ.push_back(regKnown[ins[24:20]]);
         wCycleQ.push_back(lastWasSystem && ins[24:20] == 5'd31);
      end
      7'h13, 7'h33: begin
         b  = (ins[6:0] == 7'h33) ? r2 : immI;
         sh = int'(b[4:0]);
         case (f3)
            3'd0:    res = (ins[5] && ins[30]) ? r1 - b : r1 + b;
            3'd1:    res = r1 << sh;
            3'd2:    res = {31'h0, $signed(r1) < $signed(b)};
            3'd3:    res = {31'h0, r1 < b};
            3'd4:    res = r1 ^ b;
            3'd5: begin
               if (ins[30]) begin
                  res = $signed(r1) >>> sh;
               end else begin
                  res = r1 >> sh;
               end
            end
            3'd6:    res = r1 | b;
            default: res = r1 & b;
         endcase
      end
      default: begin
         // Cycle counter read, value only seen in memory
         wr = 1'b0;
         if (rd != 0) begin
            regKnown[rd] = 1'b0;
         end
      end
   endcase
   if (wr && rd != 0) begin
      regs[rd]     = res;
      regKnown[rd] = 1'b1;
   end
   lastWasSystem = (ins[6:0] == 7'h73);
   pcModel       = nextPc;
endtask

`endif

// ==== test/femtoRv32Tb.sv ====
/*
 * Testbench for the FemtoRV32 core
 * Random RV32I program, memory with random busy cycles,
 * fetch, write and register dump checks against a reference model
 */

`timescale 1ns/1ns
`default_nettype none

module femtoRv32Tb import femtoPkg::*; ();

   localparam int MEM_WORDS      = 4096;
   localparam int NUM_RANDOM     = 300;
   localparam int TIMEOUT_CYCLES = 200000;
   localparam logic [31:0] DATA_BASE = 32'h0000_2000;
   // Offsets from x1 for cycle samples and the final dump
   localparam int CYCLE_OFF = 1024;
   localparam int DUMP_OFF  = 1536;
   localparam int DUMP_WORD = (32'h2000 + DUMP_OFF) / 4;

   logic       clk;
   logic       reset;
   wordT       memRdata;
   logic       memRbusy;
   logic       memWbusy;
   wordT       memAddr;
   wordT       memWdata;
   logic [3:0] memWmask;
   logic       memRstrb;

   integer      seed;
   logic [31:0] mem [MEM_WORDS];
   logic [31:0] refMem [MEM_WORDS];
   int          wp;
   logic [31:0] haltPc;
   logic [31:0] regs [32];
   logic        regKnown [32];
   logic [31:0] pcModel;
   logic        loadPending;
   logic [31:0] loadAddr;
   logic        lastWasSystem;
   logic [31:0] lastCycle;
   logic [31:0] wAddrQ [$];
   logic [31:0] wDataQ [$];
   logic [3:0]  wMaskQ [$];
   logic        wKnownQ [$];
   logic        wCycleQ [$];
   int          errors;
   int          rCount;
   int          wCount;
   int          haltSeen;
   logic        halted;

   `include "rv32RefModel.svh"

   femtoRv32 i_femtoRv32 (
      .clk      (clk),
      .reset    (reset),
      .memRdata (memRdata),
      .memRbusy (memRbusy),
      .memWbusy (memWbusy),
      .memAddr  (memAddr),
      .memWdata (memWdata),
      .memWmask (memWmask),
      .memRstrb (memRstrb)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic flagMismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
   endtask

   task automatic checkWrite();
      logic [31:0] lanes;
      logic [31:0] eAddr;
      logic [31:0] eData;
      logic [3:0]  eMask;
      logic        known;
      logic        isCyc;
      if (wAddrQ.size() == 0) begin
         $display("Unexpected write at %0t, the model has no store left", $time);
         errors++;
      end else begin
         eAddr = wAddrQ.pop_front();
         eData = wDataQ.pop_front();
         eMask = wMaskQ.pop_front();
         known = wKnownQ.pop_front();
         isCyc = wCycleQ.pop_front();
         // Only the lanes the model writes are compared
         lanes = {{8{eMask[3]}}, {8{eMask[2]}}, {8{eMask[1]}}, {8{eMask[0]}}};
         if (memAddr !== eAddr) begin
            flagMismatch("memAddr (write)", memAddr, eAddr);
         end
         if (memWmask !== eMask) begin
            flagMismatch("memWmask", {28'h0, memWmask}, {28'h0, eMask});
         end
         if (known && ((memWdata & lanes) !== (eData & lanes))) begin
            flagMismatch("memWdata", memWdata & lanes, eData & lanes);
         end
         // Counter samples must keep rising
         if (isCyc) begin
            if (memWdata <= lastCycle) begin
               flagMismatch("cycle sample", memWdata, lastCycle + 32'd1);
            end
            lastCycle = memWdata;
         end
      end
   endtask

   // Called once per falling edge while the DUT outputs are settled
   task automatic serviceMemory();
      if (memWmask != 4'b0000) begin
         checkWrite();
         for (int l = 0; l < 4; l++) begin
            if (memWmask[l]) begin
               mem[memAddr[13:2]][8*l +: 8] = memWdata[8*l +: 8];
            end
         end
         // Busy rises in the cycle after the write
         wCount = rnd(3);
      end else begin
         memWbusy = (wCount > 0);
         if (wCount > 0) begin
            wCount--;
         end
      end
      if (memRstrb) begin
         if (loadPending) begin
            if (memAddr !== loadAddr) begin
               flagMismatch("memAddr (load)", memAddr, loadAddr);
            end
            loadPending = 1'b0;
         end else begin
            if (memAddr !== pcModel) begin
               flagMismatch("memAddr (fetch)", memAddr, pcModel);
            end
            // Second fetch of the self jump means the program is done
            if (pcModel == haltPc) begin
               haltSeen++;
               halted = (haltSeen >= 2);
            end
            stepModel();
         end
         memRdata = mem[memAddr[13:2]];
         // Busy rises in the cycle after the strobe
         rCount   = rnd(3);
      end else begin
         memRbusy = (rCount > 0);
         if (rCount > 0) begin
            rCount--;
         end
      end
   endtask

   initial begin
      int cycleCount;
      reset         = 1'b0;
      memRdata      = '0;
      memRbusy      = 1'b0;
      memWbusy      = 1'b0;
      seed          = 88;
      errors        = 0;
      rCount        = 0;
      wCount        = 0;
      haltSeen      = 0;
      halted        = 1'b0;
      loadPending   = 1'b0;
      loadAddr      = '0;
      lastWasSystem = 1'b0;
      lastCycle     = '0;
      pcModel       = RESET_ADDR;
      for (int r = 0; r < 32; r++) begin
         regs[r]     = '0;
         regKnown[r] = 1'b1;
      end
      buildProgram();
      for (int a = 0; a < MEM_WORDS; a++) begin
         refMem[a] = mem[a];
      end
      // Two reset cycles with no bus activity
      repeat (2) begin
         @(negedge clk);
         if (memRstrb !== 1'b0) begin
            flagMismatch("memRstrb (reset)", {31'h0, memRstrb}, 32'h0);
         end
         if (memWmask !== 4'b0000) begin
            flagMismatch("memWmask (reset)", {28'h0, memWmask}, 32'h0);
         end
      end
      reset = 1'b1;
      cycleCount = 0;
      while (!halted && cycleCount < TIMEOUT_CYCLES) begin
         @(negedge clk);
         serviceMemory();
         cycleCount++;
      end
      if (!halted) begin
         $display("Timeout after %0d cycles, the halt loop was never fetched", cycleCount);
         errors++;
      end else begin
         if (wAddrQ.size() != 0) begin
            $display("The model still expects %0d writes at the end", wAddrQ.size());
            errors++;
         end
         // x31 holds a cycle sample and is not compared
         for (int r = 1; r < 31; r++) begin
            if (mem[DUMP_WORD + r] !== regs[r]) begin
               flagMismatch($sformatf("x%0d", r), mem[DUMP_WORD + r], regs[r]);
            end
         end
      end
      $display("Errors: %0d, cycles run: %0d", errors, cycleCount);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== files.f ====
source/femtoPkg.sv
source/instrDecoder.sv
source/registerFile.sv
source/aluUnit.sv
source/loadStoreAlign.sv
source/fetchExecControl.sv
source/femtoRv32.sv
+incdir+include
test/femtoRv32Tb.sv

// ==== Makefile ====
# Verilator build and run for the FemtoRV32 testbench

OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module femtoRv32Tb -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/VfemtoRv32Tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
